//--- design/fetch_pkg.sv
// fetch frontend package
// widths, predictor table sizes, rv32 opcodes and the instruction word views
// shared by the scanner, the predictors and the pc generator

package fetch_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int unsigned XLEN        = 32;
    localparam int unsigned BHT_ENTRIES = 64;
    // counter index comes from pc bits 7:2
    localparam int unsigned BHT_IDX_W   = 6;
    localparam int unsigned RAS_DEPTH   = 4;

    // --------------------------------------------------
    // opcodes and link registers
    // --------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // x1 is ra, x5 is the alternate link register (t0)
    localparam logic [4:0] RA_REG     = 5'd1;
    localparam logic [4:0] ALT_RA_REG = 5'd5;

    // --------------------------------------------------
    // instruction word views
    // --------------------------------------------------
    // conditional branch, immediate scattered over both ends of the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // jal, 20-bit offset in halfwords
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // jalr and other register-immediate forms
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one fetched word, read as whichever format the opcode calls for
    typedef union packed {
        b_type_t b;
        j_type_t j;
        i_type_t i;
    } instr_t;

endpackage

//--- design/instr_scan.sv
// instruction scanner
// classifies one rv32 word as branch, jal, jalr, call or return
// and extracts the sign-extended branch or jump offset

`timescale 1ns/1ps

module instr_scan import fetch_pkg::*; (
    input  instr_t            instr_i,
    output logic              is_branch_o,
    output logic              is_jal_o,
    output logic              is_jalr_o,
    output logic              is_call_o,
    output logic              is_return_o,
    output logic [XLEN-1:0]   imm_o
);

    logic            op_branch;
    logic            op_jal;
    logic            op_jalr;
    logic            rd_link;
    logic            rs1_link;
    logic            rd_zero;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;

    // --------------------------------------------------
    // opcode and register decode
    // --------------------------------------------------
    // opcode, rd and rs1 sit at the same place in every format
    assign op_branch = (instr_i.i.opcode == OPC_BRANCH);
    assign op_jal    = (instr_i.i.opcode == OPC_JAL);
    assign op_jalr   = (instr_i.i.opcode == OPC_JALR);

    assign rd_link  = (instr_i.j.rd == RA_REG) || (instr_i.j.rd == ALT_RA_REG);
    assign rs1_link = (instr_i.i.rs1 == RA_REG) || (instr_i.i.rs1 == ALT_RA_REG);
    assign rd_zero  = (instr_i.i.rd == 5'd0);

    // --------------------------------------------------
    // control-flow classes
    // --------------------------------------------------
    assign is_branch_o = op_branch;
    assign is_jal_o    = op_jal;
    // jalr x0, 0(ra) style returns go to the stack, not the plain jalr path
    assign is_return_o = op_jalr && rd_zero && rs1_link;
    assign is_jalr_o   = op_jalr && !is_return_o;
    // a call links through ra or t0
    assign is_call_o   = (op_jal || op_jalr) && rd_link;

    // --------------------------------------------------
    // immediates
    // --------------------------------------------------
    // b-type offset, bit 0 is implied zero
    assign b_imm = {{(XLEN-13){instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};

    // j-type offset
    assign j_imm = {{(XLEN-21){instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

    always_comb begin
        imm_o = '0;
        if (op_jal) begin
            imm_o = j_imm;
        end else if (op_branch) begin
            imm_o = b_imm;
        end
    end

endmodule

//--- design/branch_history.sv
// branch history table
// direct-mapped 2-bit saturating counters indexed by pc bits 7:2,
// combinational prediction read and clocked update from branch resolution

`timescale 1ns/1ps

module branch_history import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] pc_i,
    input  logic            update_i,
    input  logic [XLEN-1:0] update_pc_i,
    input  logic            update_taken_i,
    output logic            valid_o,
    output logic            taken_o
);

    logic [BHT_ENTRIES-1:0] valid_q;
    logic [1:0]             cnt_q [BHT_ENTRIES];
    logic [BHT_IDX_W-1:0]   rd_idx;
    logic [BHT_IDX_W-1:0]   upd_idx;
    logic [1:0]             cnt_next;

    assign rd_idx  = pc_i[BHT_IDX_W+1:2];
    assign upd_idx = update_pc_i[BHT_IDX_W+1:2];

    // --------------------------------------------------
    // prediction
    // --------------------------------------------------
    assign valid_o = valid_q[rd_idx];
    // upper counter bit means weakly or strongly taken
    assign taken_o = valid_q[rd_idx] && cnt_q[rd_idx][1];

    // --------------------------------------------------
    // update
    // --------------------------------------------------
    always_comb begin
        cnt_next = cnt_q[upd_idx];
        if (!valid_q[upd_idx]) begin
            // first outcome seeds a weak state in its direction
            cnt_next = update_taken_i ? 2'd2 : 2'd1;
        end else if (update_taken_i) begin
            if (cnt_q[upd_idx] != 2'd3) cnt_next = cnt_q[upd_idx] + 2'd1;
        end else begin
            if (cnt_q[upd_idx] != 2'd0) cnt_next = cnt_q[upd_idx] - 2'd1;
        end
    end

    // valid bits, all entries cold after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // counter array
    always_ff @(posedge clk_i) begin
        if (update_i) begin
            cnt_q[upd_idx] <= cnt_next;
        end
    end

endmodule

//--- design/return_stack.sv
// return address stack
// small shift stack, entry 0 is the top; a push when full drops the oldest

`timescale 1ns/1ps

module return_stack import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            push_i,
    input  logic            pop_i,
    input  logic [XLEN-1:0] data_i,
    output logic            valid_o,
    output logic [XLEN-1:0] top_o
);

    logic [RAS_DEPTH-1:0] valid_q;
    logic [XLEN-1:0]      addr_q [RAS_DEPTH];

    assign valid_o = valid_q[0];
    assign top_o   = addr_q[0];

    // --------------------------------------------------
    // occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (push_i) begin
            // oldest bit falls off the bottom
            valid_q <= {valid_q[RAS_DEPTH-2:0], 1'b1};
        end else if (pop_i) begin
            valid_q <= {1'b0, valid_q[RAS_DEPTH-1:1]};
        end
    end

    // --------------------------------------------------
    // return addresses
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_q[0] <= data_i;
            for (int i = 1; i < RAS_DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
            end
        end else if (pop_i) begin
            for (int i = 0; i < RAS_DEPTH-1; i++) begin
                addr_q[i] <= addr_q[i+1];
            end
        end
    end

    // the pc generator only pops once it has seen a valid top
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_q[0])
        else $error("return_stack: pop on empty stack");

endmodule

//--- design/pc_gen.sv
// pc generator
// combines scanner flags, counter prediction and stack top into a next pc,
// applies backend redirects and registers the fetch entry for decode

`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic            is_call_i,
    input  logic            is_return_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic            bht_valid_i,
    input  logic            bht_taken_i,
    input  logic            ras_valid_i,
    input  logic [XLEN-1:0] ras_top_i,
    input  logic            resolve_valid_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_i,
    input  logic            set_pc_commit_i,
    input  logic [XLEN-1:0] pc_commit_i,
    output logic [XLEN-1:0] fetch_addr_o,
    output logic            ras_push_o,
    output logic            ras_pop_o,
    output logic [XLEN-1:0] ras_data_o,
    output logic            entry_valid_o,
    output logic [XLEN-1:0] entry_pc_o,
    output logic [XLEN-1:0] entry_instr_o,
    output logic            entry_taken_o,
    output logic [XLEN-1:0] entry_target_o
);

    // first cycle out of reset fetches from the boot address
    logic            boot_load_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] pc_plus4;
    logic            redirect;
    logic            accept;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    assign fetch_addr_o = boot_load_q ? boot_addr_i : pc_q;
    assign pc_plus4     = fetch_addr_o + XLEN'(4);

    // any backend redirect drops the word fetched this cycle
    assign redirect = (resolve_valid_i && resolve_mispredict_i) || eret_i
                   || ex_valid_i || set_pc_commit_i;
    assign accept   = instr_valid_i && !redirect;

    // --------------------------------------------------
    // prediction
    // --------------------------------------------------
    always_comb begin
        pred_taken  = 1'b0;
        pred_target = '0;
        if (is_branch_i) begin
            // dynamic counter if trained, else backward taken
            pred_taken  = bht_valid_i ? bht_taken_i : imm_i[XLEN-1];
            pred_target = fetch_addr_o + imm_i;
        end else if (is_jal_i) begin
            pred_taken  = 1'b1;
            pred_target = fetch_addr_o + imm_i;
        end else if (is_return_i) begin
            pred_taken  = ras_valid_i;
            pred_target = ras_valid_i ? ras_top_i : '0;
        end else if (is_jalr_i) begin
            // no target buffer, fall through
            pred_taken  = 1'b0;
            pred_target = '0;
        end
    end

    // stack only moves for words that really leave fetch
    assign ras_push_o = accept && is_call_i;
    assign ras_pop_o  = accept && is_return_i && ras_valid_i;
    assign ras_data_o = pc_plus4;

    // --------------------------------------------------
    // next pc, lowest priority first
    // --------------------------------------------------
    always_comb begin
        npc = fetch_addr_o;
        if (accept) npc = pred_taken ? pred_target : pc_plus4;
        if (resolve_valid_i && resolve_mispredict_i) npc = resolve_target_i;
        if (eret_i) npc = epc_i;
        if (ex_valid_i) npc = trap_vector_i;
        // restart right behind the committing instruction
        if (set_pc_commit_i) npc = pc_commit_i + XLEN'(4);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q   <= 1'b1;
            pc_q          <= '0;
            entry_valid_o <= 1'b0;
        end else begin
            boot_load_q   <= 1'b0;
            pc_q          <= npc;
            entry_valid_o <= accept;
        end
    end

    // entry payload for decode
    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_pc_o     <= fetch_addr_o;
            entry_instr_o  <= instr_i;
            entry_taken_o  <= pred_taken;
            entry_target_o <= pred_target;
        end
    end

    // an aligned pc stays aligned unless a backend redirect moves it off
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_addr_o[1:0] == 2'b00 && !redirect)
        |=> fetch_addr_o[1:0] == 2'b00)
        else $error("pc_gen: fetch address lost word alignment");

endmodule

//--- design/fetch_frontend.sv
// instruction fetch frontend
// scanner and history table look at the same fetch word and pc,
// pc_gen merges them with the return stack and drives the next fetch

`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    // memory side
    output logic [XLEN-1:0] fetch_addr_o,
    input  logic [XLEN-1:0] instr_i,
    input  logic            instr_valid_i,
    // branch resolution
    input  logic            resolve_valid_i,
    input  logic            resolve_branch_i,
    input  logic [XLEN-1:0] resolve_pc_i,
    input  logic            resolve_taken_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    // csr and commit redirects
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_i,
    input  logic            set_pc_commit_i,
    input  logic [XLEN-1:0] pc_commit_i,
    // decode side
    output logic            entry_valid_o,
    output logic [XLEN-1:0] entry_pc_o,
    output logic [XLEN-1:0] entry_instr_o,
    output logic            entry_taken_o,
    output logic [XLEN-1:0] entry_target_o
);

    logic            is_branch, is_jal, is_jalr, is_call, is_return;
    logic [XLEN-1:0] imm;
    logic            bht_valid, bht_taken;
    logic            ras_push, ras_pop, ras_valid;
    logic [XLEN-1:0] ras_data, ras_top;

    instr_scan i_instr_scan (
        .instr_i     (instr_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_call_o   (is_call),
        .is_return_o (is_return),
        .imm_o       (imm)
    );

    // only conditional branches train the counters
    branch_history i_branch_history (
        .clk_i, .rst_ni,
        .pc_i           (fetch_addr_o),
        .update_i       (resolve_valid_i && resolve_branch_i),
        .update_pc_i    (resolve_pc_i),
        .update_taken_i (resolve_taken_i),
        .valid_o        (bht_valid),
        .taken_o        (bht_taken)
    );

    return_stack i_return_stack (
        .clk_i, .rst_ni,
        .push_i  (ras_push),
        .pop_i   (ras_pop),
        .data_i  (ras_data),
        .valid_o (ras_valid),
        .top_o   (ras_top)
    );

    pc_gen i_pc_gen (
        .clk_i, .rst_ni, .boot_addr_i, .instr_valid_i, .instr_i,
        .is_branch_i (is_branch), .is_jal_i (is_jal), .is_jalr_i (is_jalr),
        .is_call_i (is_call), .is_return_i (is_return), .imm_i (imm),
        .bht_valid_i (bht_valid), .bht_taken_i (bht_taken),
        .ras_valid_i (ras_valid), .ras_top_i (ras_top),
        .resolve_valid_i, .resolve_mispredict_i, .resolve_target_i,
        .eret_i, .epc_i, .ex_valid_i, .trap_vector_i, .set_pc_commit_i, .pc_commit_i,
        .fetch_addr_o,
        .ras_push_o (ras_push), .ras_pop_o (ras_pop), .ras_data_o (ras_data),
        .entry_valid_o, .entry_pc_o, .entry_instr_o, .entry_taken_o, .entry_target_o
    );

endmodule

//--- testbench/tb_tasks.svh
// directed tests for the fetch frontend
// rv32 word encoders, a reference prediction model, the value check and five tests

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// return addresses the model expects, most recent first
logic [XLEN-1:0] ras_model [$];

// --------------------------------------------------
// encoders and reference model
// --------------------------------------------------
// bne x1, x2, off
function automatic logic [XLEN-1:0] branch_word(input logic [XLEN-1:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [XLEN-1:0] jal_word(input logic [4:0] rd, input logic [XLEN-1:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// jalr rd, 0(rs1)
function automatic logic [XLEN-1:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, 7'b1100111};
endfunction

// trained counter if there is one, else backward taken
function automatic logic branch_prediction(input logic cnt_valid, input logic [1:0] cnt,
                                           input logic [XLEN-1:0] off);
    return cnt_valid ? cnt[1] : off[XLEN-1];
endfunction

// first outcome seeds 2 or 1, then saturate at 0 and 3
function automatic logic [1:0] trained_counter(input logic cnt_valid, input logic [1:0] cnt,
                                               input logic taken);
    if (!cnt_valid) return taken ? 2'd2 : 2'd1;
    if (taken) return (cnt == 2'd3) ? cnt : cnt + 2'd1;
    return (cnt == 2'd0) ? cnt : cnt - 2'd1;
endfunction

// --------------------------------------------------
// stimulus and checking
// --------------------------------------------------
task automatic step();
    @(posedge clk);
    #1;
endtask

task automatic check(input string what, input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        test_errors++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic clear_redirects();
    resolve_valid      = 1'b0;
    resolve_branch     = 1'b0;
    resolve_taken      = 1'b0;
    resolve_mispredict = 1'b0;
    resolve_pc         = '0;
    resolve_target     = '0;
    eret               = 1'b0;
    epc                = '0;
    ex_valid           = 1'b0;
    trap_vector        = '0;
    set_pc_commit      = 1'b0;
    pc_commit          = '0;
endtask

task automatic put_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] word);
    mem[addr[MEM_IDX_W+1:2]] = word;
endtask

// fresh memory image and a 10-cycle reset, no entry may show up meanwhile
task automatic restart_dut();
    test_errors = 0;
    ras_model.delete();
    for (int i = 0; i < MEM_WORDS; i++) begin
        // op-imm word, upper fields carry the word index
        mem[i] = {i[24:0], 7'b0010011};
    end
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    clear_redirects();
    repeat (10) begin
        step();
        check("entry valid in reset", XLEN'(entry_valid), '0);
    end
    rst_n = 1'b1;
endtask

task automatic expect_entry(input logic [XLEN-1:0] pc, input logic taken,
                            input logic [XLEN-1:0] target, input logic with_target);
    int n;
    n = 0;
    step();
    while (!entry_valid && n < ENTRY_WAIT) begin
        step();
        n++;
    end
    if (!entry_valid) begin
        errors++;
        test_errors++;
        $display("no fetch entry for pc %h within %0d cycles", pc, ENTRY_WAIT);
    end
    check("entry pc", entry_pc, pc);
    check("entry instr", entry_instr, mem[pc[MEM_IDX_W+1:2]]);
    check("entry taken", XLEN'(entry_taken), XLEN'(taken));
    if (with_target) begin
        check("entry target", entry_target, target);
    end
endtask

task automatic expect_call(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] off);
    expect_entry(pc, 1'b1, pc + off, 1'b1);
    ras_model.push_front(pc + 32'd4);
endtask

task automatic expect_return(input logic [XLEN-1:0] pc);
    if (ras_model.size() > 0) begin
        expect_entry(pc, 1'b1, ras_model.pop_front(), 1'b1);
    end else begin
        // nothing to predict from, fetch falls through
        expect_entry(pc, 1'b0, '0, 1'b0);
    end
endtask

task automatic finish_test(input string name);
    $display("test %-16s done with %0d errors", name, test_errors);
endtask

// --------------------------------------------------
// tests
// --------------------------------------------------
task automatic test_sequential();
    restart_dut();
    // memory holds back right after reset
    repeat (3) begin
        step();
        check("entry valid in stall", XLEN'(entry_valid), '0);
        check("fetch addr in stall", fetch_addr, BOOT_ADDR);
    end
    instr_valid = 1'b1;
    for (int k = 0; k < 6; k++) begin
        expect_entry(BOOT_ADDR + XLEN'(4 * k), 1'b0, '0, 1'b0);
    end
    instr_valid = 1'b0;
    repeat (2) begin
        step();
        check("entry valid in stall", XLEN'(entry_valid), '0);
        check("fetch addr in stall", fetch_addr, BOOT_ADDR + 32'd24);
    end
    finish_test("sequential");
endtask

task automatic test_static_jal();
    logic [XLEN-1:0] fwd_off;
    logic [XLEN-1:0] back_off;
    logic [XLEN-1:0] br_pc;
    logic [XLEN-1:0] far_pc;
    fwd_off  = 32'h0000_0040;
    back_off = 32'hFFFF_FF80;
    restart_dut();
    // backward branch sits in one of the eight words after the forward one
    br_pc  = BOOT_ADDR + 32'd8 + XLEN'(4 * ($random(seed) & 7));
    far_pc = br_pc + back_off;
    put_word(BOOT_ADDR + 32'd4, branch_word(fwd_off));
    put_word(br_pc, branch_word(back_off));
    put_word(far_pc, jal_word(5'd0, 32'h100));
    instr_valid = 1'b1;
    expect_entry(BOOT_ADDR, 1'b0, '0, 1'b0);
    expect_entry(BOOT_ADDR + 32'd4, branch_prediction(1'b0, 2'd0, fwd_off),
                 BOOT_ADDR + 32'd4 + fwd_off, 1'b1);
    for (logic [XLEN-1:0] a = BOOT_ADDR + 32'd8; a < br_pc; a += 4) begin
        expect_entry(a, 1'b0, '0, 1'b0);
    end
    expect_entry(br_pc, branch_prediction(1'b0, 2'd0, back_off), far_pc, 1'b1);
    expect_entry(far_pc, 1'b1, far_pc + 32'h100, 1'b1);
    expect_entry(far_pc + 32'h100, 1'b0, '0, 1'b0);
    instr_valid = 1'b0;
    finish_test("static_jal");
endtask

task automatic test_counter_training();
    logic [XLEN-1:0] br_pc;
    logic [1:0]      cnt;
    logic            cnt_valid;
    logic [9:0]      outcomes;
    // applied from bit 0 upward, walks the counter to both ends
    outcomes  = 10'b0110000111;
    cnt       = 2'd0;
    cnt_valid = 1'b0;
    restart_dut();
    br_pc = BOOT_ADDR + 32'h40 + XLEN'(4 * ($random(seed) & 15));
    put_word(br_pc, branch_word(32'h20));
    for (int i = 0; i <= 10; i++) begin
        if (i > 0) begin
            resolve_valid  = 1'b1;
            resolve_branch = 1'b1;
            resolve_pc     = br_pc;
            resolve_taken  = outcomes[i-1];
            step();
            clear_redirects();
            cnt       = trained_counter(cnt_valid, cnt, outcomes[i-1]);
            cnt_valid = 1'b1;
        end
        // back to the branch through a commit redirect
        set_pc_commit = 1'b1;
        pc_commit     = br_pc - 32'd4;
        step();
        clear_redirects();
        instr_valid = 1'b1;
        expect_entry(br_pc, branch_prediction(cnt_valid, cnt, 32'h20), br_pc + 32'h20, 1'b1);
        instr_valid = 1'b0;
    end
    finish_test("counter_training");
endtask

task automatic test_call_return();
    restart_dut();
    // two nested calls through ra, unwound through ra and t0
    put_word(BOOT_ADDR, jal_word(5'd1, 32'h40));
    put_word(BOOT_ADDR + 32'h40, jal_word(5'd1, 32'h40));
    put_word(BOOT_ADDR + 32'h84, jalr_word(5'd0, 5'd1));
    put_word(BOOT_ADDR + 32'h44, jalr_word(5'd0, 5'd5));
    // one return too many
    put_word(BOOT_ADDR + 32'h04, jalr_word(5'd0, 5'd1));
    instr_valid = 1'b1;
    expect_call(BOOT_ADDR, 32'h40);
    expect_call(BOOT_ADDR + 32'h40, 32'h40);
    expect_entry(BOOT_ADDR + 32'h80, 1'b0, '0, 1'b0);
    expect_return(BOOT_ADDR + 32'h84);
    expect_return(BOOT_ADDR + 32'h44);
    expect_return(BOOT_ADDR + 32'h04);
    expect_entry(BOOT_ADDR + 32'h08, 1'b0, '0, 1'b0);
    instr_valid = 1'b0;
    finish_test("call_return");
endtask

task automatic test_redirects();
    logic [3:0]      cases [10];
    logic [3:0]      sel;
    logic [XLEN-1:0] exp_pc;
    // bit 0 mispredict, 1 eret, 2 exception, 3 commit
    cases = '{4'b1111, 4'b0111, 4'b0011, 4'b0001, 4'b1000,
              4'b0100, 4'b0010, 4'b1010, 4'b0101, 4'b0110};
    restart_dut();
    instr_valid = 1'b1;
    expect_entry(BOOT_ADDR, 1'b0, '0, 1'b0);
    for (int i = 0; i < 10; i++) begin
        sel                = cases[i];
        resolve_valid      = sel[0];
        resolve_mispredict = sel[0];
        resolve_target     = 32'h200;
        eret               = sel[1];
        epc                = 32'h240;
        ex_valid           = sel[2];
        trap_vector        = 32'h280;
        set_pc_commit      = sel[3];
        pc_commit          = 32'h2c0;
        // higher priority sources override
        exp_pc = 32'h200;
        if (sel[1]) exp_pc = 32'h240;
        if (sel[2]) exp_pc = 32'h280;
        if (sel[3]) exp_pc = 32'h2c4;
        step();
        clear_redirects();
        check("fetch addr after redirect", fetch_addr, exp_pc);
        check("entry valid after redirect", XLEN'(entry_valid), '0);
        expect_entry(exp_pc, 1'b0, '0, 1'b0);
    end
    instr_valid = 1'b0;
    finish_test("redirects");
endtask

`endif

//--- testbench/tb_fetch_frontend.sv
// fetch frontend testbench
// word memory model behind the fetch port, watchdog and the directed test sequence

`timescale 1ns/1ps

module tb_fetch_frontend import fetch_pkg::*; ();

    localparam int          CLK_PERIOD  = 10;
    localparam int          MEM_WORDS   = 256;
    localparam int          MEM_IDX_W   = 8;
    localparam int          ENTRY_WAIT  = 20;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_0080;
    // cycle budgets of the five tests, reset included
    localparam int          TEST_CYCLES = 40 + 40 + 90 + 40 + 60;
    localparam int          WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] boot_addr;
    logic [XLEN-1:0] fetch_addr;
    logic [XLEN-1:0] instr;
    logic            instr_valid;
    logic            resolve_valid, resolve_branch, resolve_taken, resolve_mispredict;
    logic [XLEN-1:0] resolve_pc, resolve_target;
    logic            eret, ex_valid, set_pc_commit;
    logic [XLEN-1:0] epc, trap_vector, pc_commit;
    logic            entry_valid, entry_taken;
    logic [XLEN-1:0] entry_pc, entry_instr, entry_target;

    // instruction memory, one word per fetch address
    logic [XLEN-1:0] mem [MEM_WORDS];
    int              seed;
    int              checks;
    int              errors;
    int              test_errors;

    // same-cycle read, the fetch port has no latency
    assign instr = mem[fetch_addr[MEM_IDX_W+1:2]];

    fetch_frontend DUT (
        .clk_i (clk), .rst_ni (rst_n), .boot_addr_i (boot_addr),
        .fetch_addr_o (fetch_addr), .instr_i (instr), .instr_valid_i (instr_valid),
        .resolve_valid_i (resolve_valid), .resolve_branch_i (resolve_branch),
        .resolve_pc_i (resolve_pc), .resolve_taken_i (resolve_taken),
        .resolve_mispredict_i (resolve_mispredict), .resolve_target_i (resolve_target),
        .eret_i (eret), .epc_i (epc), .ex_valid_i (ex_valid), .trap_vector_i (trap_vector),
        .set_pc_commit_i (set_pc_commit), .pc_commit_i (pc_commit),
        .entry_valid_o (entry_valid), .entry_pc_o (entry_pc), .entry_instr_o (entry_instr),
        .entry_taken_o (entry_taken), .entry_target_o (entry_target)
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a test stopped making progress", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed        = 67;
        checks      = 0;
        errors      = 0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        boot_addr   = BOOT_ADDR;
        clear_redirects();
        test_sequential();
        test_static_jal();
        test_counter_training();
        test_call_return();
        test_redirects();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
design/fetch_pkg.sv
design/instr_scan.sv
design/branch_history.sv
design/return_stack.sv
design/pc_gen.sv
design/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

//--- Makefile
# Verilator build and run of the fetch frontend testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Testbench failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run and search $(LOG) for the failure message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
